// File: design/mmu_settings.svh
// Address, page, TLB set and SPR group settings of the data MMU
`ifndef MMU_SETTINGS_SVH
`define MMU_SETTINGS_SVH

// Operand and address width
`define MMU_ADDR_WIDTH 32

// 8 KB pages
`define MMU_PAGE_BITS 13

// 64 sets, one way
`define MMU_SET_WIDTH 6

// Compared with spr_addr[15:11]
`define MMU_SPR_GROUP 1

`endif

// File: design/mmu_types_pkg.sv
// Page-table entry, TLB match and translate entries, walker states
`include "mmu_settings.svh"

package mmu_types_pkg;

   // Page-table entry as stored in memory
   typedef struct packed {
      logic [`MMU_ADDR_WIDTH-`MMU_PAGE_BITS-1:0] ppn;
      logic [1:0]                                rsvd;
      logic                                      present;
      logic                                      huge;
      logic                                      exec;
      logic                                      write;
      logic                                      user;
      // Dirty, accessed, WOM, writeback, cache inhibit, coherent
      logic [5:0]                                attr;
   } pte_t;

   typedef struct packed {
      logic [`MMU_ADDR_WIDTH-`MMU_PAGE_BITS-1:0] vpn;
      logic [`MMU_PAGE_BITS-2:0]                 rsvd;
      logic                                      valid;
   } match_entry_t;

   typedef struct packed {
      logic [`MMU_ADDR_WIDTH-`MMU_PAGE_BITS-1:0] ppn;
      logic [`MMU_PAGE_BITS-11:0]                rsvd;
      logic                                      swe;
      logic                                      sre;
      logic                                      uwe;
      logic                                      ure;
      logic [5:0]                                attr;
   } trans_entry_t;

   typedef enum logic [1:0] {
      WALK_IDLE,
      WALK_PTR,
      WALK_PTE,
      WALK_SETTLE
   } walk_state_t;

endpackage

// File: design/spr_map_pkg.sv
// SPR address map of the data MMU group and decoded target type
package spr_map_pkg;

   // Control register, page-table base in bits 31:10
   localparam logic [15:0] SPR_DMMUCR_ADDR     = 16'h0800;

   // Way 0 match entries, one per set
   localparam logic [15:0] SPR_DTLB_MATCH_BASE = 16'h0A00;

   // Way 0 translate entries
   localparam logic [15:0] SPR_DTLB_TRANS_BASE = 16'h0A80;

   // First address past way 0
   localparam logic [15:0] SPR_DTLB_WAY_END    = 16'h0B00;

   typedef enum logic [1:0] {
      SPR_SEL_NONE,
      SPR_SEL_CTRL,
      SPR_SEL_MATCH,
      SPR_SEL_TRANS
   } spr_sel_t;

endpackage

// File: design/tlb_dpram.sv
// Two-port synchronous TLB array with a typed entry
module tlb_dpram #(
   parameter type entry_t    = logic [31:0],
   parameter int  ADDR_WIDTH = 6
) (
   input  logic                  clk,
   // Lookup port, read only
   input  logic [ADDR_WIDTH-1:0] a_addr_i,
   output entry_t                a_rdata_o,
   // Maintenance port, SPR access or refill
   input  logic [ADDR_WIDTH-1:0] b_addr_i,
   input  logic                  b_we_i,
   input  entry_t                b_wdata_i,
   output entry_t                b_rdata_o
);

   entry_t mem_q [0:2**ADDR_WIDTH-1];

   // Registered reads, old data on a same-cycle write
   always_ff @(posedge clk) begin
      a_rdata_o <= mem_q[a_addr_i];
      b_rdata_o <= mem_q[b_addr_i];
      if (b_we_i) begin
         mem_q[b_addr_i] <= b_wdata_i;
      end
   end

   // The MMU steers port A off any set that port B writes
   a_no_collision: assert property (
      @(posedge clk) b_we_i |-> a_addr_i != b_addr_i
   ) else $error("port B writes set %0d while port A reads it", b_addr_i);

endmodule

// File: design/tlb_reload_walker.sv
// Two-level page-table walker that builds TLB refill entries
`include "mmu_settings.svh"

module tlb_reload_walker
   import mmu_types_pkg::*;
(
   input  logic                        clk,
   input  logic                        rst,
   // Walk control
   input  logic                        walk_start_i,
   input  logic [`MMU_ADDR_WIDTH-1:0]  walk_vaddr_i,
   input  logic [`MMU_ADDR_WIDTH-11:0] walk_ptbr_i,
   output logic                        walk_busy_o,
   output logic                        walk_done_o,
   output logic                        walk_fault_o,
   // Page-table memory
   output logic                        mem_req_o,
   output logic [`MMU_ADDR_WIDTH-1:0]  mem_addr_o,
   input  logic                        mem_ack_i,
   input  logic [`MMU_ADDR_WIDTH-1:0]  mem_data_i,
   // Refill toward the arrays
   output logic                        refill_we_o,
   output match_entry_t                refill_match_o,
   output trans_entry_t                refill_trans_o
);

   walk_state_t                 state_q;
   logic [`MMU_ADDR_WIDTH-1:0]  vaddr_q;
   pte_t                        pte;

   assign pte         = pte_t'(mem_data_i);
   assign walk_busy_o = state_q != WALK_IDLE;

   always_ff @(posedge clk) begin
      if (rst) begin
         state_q      <= WALK_IDLE;
         mem_req_o    <= 1'b0;
         walk_done_o  <= 1'b0;
         walk_fault_o <= 1'b0;
         refill_we_o  <= 1'b0;
      end else begin
         walk_done_o  <= 1'b0;
         walk_fault_o <= 1'b0;
         refill_we_o  <= 1'b0;
         case (state_q)
            WALK_IDLE: begin
               if (walk_start_i) begin
                  mem_req_o <= 1'b1;
                  state_q   <= WALK_PTR;
               end
            end
            // First level, request stays up for the second fetch
            WALK_PTR: begin
               if (mem_ack_i) begin
                  if (pte.ppn == '0 || pte.huge) begin
                     mem_req_o    <= 1'b0;
                     walk_fault_o <= 1'b1;
                     state_q      <= WALK_IDLE;
                  end else begin
                     state_q <= WALK_PTE;
                  end
               end
            end
            WALK_PTE: begin
               if (mem_ack_i) begin
                  mem_req_o <= 1'b0;
                  if (!pte.present) begin
                     walk_fault_o <= 1'b1;
                     state_q      <= WALK_IDLE;
                  end else begin
                     refill_we_o <= 1'b1;
                     state_q     <= WALK_SETTLE;
                  end
               end
            end
            // Refill is written here, done follows
            default: begin
               walk_done_o <= 1'b1;
               state_q     <= WALK_IDLE;
            end
         endcase
      end
   end

   // Address and refill payload
   always_ff @(posedge clk) begin
      if (state_q == WALK_IDLE && walk_start_i) begin
         vaddr_q    <= walk_vaddr_i;
         mem_addr_o <= {walk_ptbr_i, walk_vaddr_i[31:24], 2'b00};
      end else if (state_q == WALK_PTR && mem_ack_i) begin
         mem_addr_o <= {pte.ppn, vaddr_q[23:`MMU_PAGE_BITS], 2'b00};
      end
      if (state_q == WALK_PTE && mem_ack_i) begin
         refill_match_o.vpn   <= vaddr_q[`MMU_ADDR_WIDTH-1:`MMU_PAGE_BITS];
         refill_match_o.rsvd  <= '0;
         refill_match_o.valid <= 1'b1;
         refill_trans_o.ppn   <= pte.ppn;
         refill_trans_o.rsvd  <= '0;
         // Supervisor may always read
         refill_trans_o.swe   <= pte.write;
         refill_trans_o.sre   <= 1'b1;
         refill_trans_o.uwe   <= pte.write & pte.user;
         refill_trans_o.ure   <= pte.user;
         refill_trans_o.attr  <= pte.attr;
      end
   end

   a_addr_stable: assert property (
      @(posedge clk) disable iff (rst)
      mem_req_o && !mem_ack_i |=> $stable(mem_addr_o)
   ) else $error("walker address changed before acknowledge");

endmodule

// File: design/dmmu.sv
// Data MMU lookup, permission check, SPR decode, control register and array port arbitration
`include "mmu_settings.svh"

module dmmu
   import mmu_types_pkg::*;
   import spr_map_pkg::*;
(
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        enable_i,
   // Translation request
   input  logic                        req_valid_i,
   output logic                        req_ready_o,
   input  logic [`MMU_ADDR_WIDTH-1:0]  req_vaddr_i,
   input  logic                        req_store_i,
   input  logic                        req_super_i,
   // Translation response
   output logic                        resp_valid_o,
   input  logic                        resp_ready_i,
   output logic [`MMU_ADDR_WIDTH-1:0]  resp_paddr_o,
   output logic                        resp_cache_inhibit_o,
   output logic                        resp_miss_o,
   output logic                        resp_pagefault_o,
   output logic                        resp_reload_fault_o,
   // SPR bus
   input  logic                        spr_stb_i,
   input  logic                        spr_we_i,
   input  logic [15:0]                 spr_addr_i,
   input  logic [`MMU_ADDR_WIDTH-1:0]  spr_dat_i,
   output logic [`MMU_ADDR_WIDTH-1:0]  spr_dat_o,
   output logic                        spr_ack_o,
   // TLB arrays
   output logic [`MMU_SET_WIDTH-1:0]   a_addr_o,
   output logic [`MMU_SET_WIDTH-1:0]   b_addr_o,
   output logic                        b_we_match_o,
   output logic                        b_we_trans_o,
   output match_entry_t                b_wmatch_o,
   output trans_entry_t                b_wtrans_o,
   input  match_entry_t                a_match_i,
   input  trans_entry_t                a_trans_i,
   input  match_entry_t                b_match_i,
   input  trans_entry_t                b_trans_i,
   // Walker
   output logic                        walk_start_o,
   output logic [`MMU_ADDR_WIDTH-1:0]  walk_vaddr_o,
   output logic [`MMU_ADDR_WIDTH-11:0] walk_ptbr_o,
   input  logic                        walk_busy_i,
   input  logic                        walk_done_i,
   input  logic                        walk_fault_i,
   input  logic                        refill_we_i,
   input  match_entry_t                refill_match_i,
   input  trans_entry_t                refill_trans_i
);

   localparam int AW = `MMU_ADDR_WIDTH;
   localparam int PB = `MMU_PAGE_BITS;
   localparam int SW = `MMU_SET_WIDTH;

   logic          busy_q;
   logic          lookup_q;
   logic          accept;
   logic [AW-1:0] vaddr_q;
   logic          store_q;
   logic          super_q;
   logic          hit;
   logic          perm_ok;
   logic          do_reload;
   logic          finish;
   logic [SW-1:0] lookup_set;
   logic          spr_group;
   logic          spr_first;
   logic          spr_wr;
   logic          refill_wr;
   spr_sel_t      spr_sel;
   spr_sel_t      spr_sel_q;
   logic [AW-1:0] ctrl_q;

   // One request in flight, SPR and walker own port B first
   assign req_ready_o = !busy_q && !spr_stb_i && !walk_busy_i;
   assign accept      = req_valid_i && req_ready_o;

   assign hit     = a_match_i.valid && a_match_i.vpn == vaddr_q[AW-1:PB];
   assign perm_ok = super_q ? (store_q ? a_trans_i.swe : a_trans_i.sre)
                            : (store_q ? a_trans_i.uwe : a_trans_i.ure);

   // A zero page-table base turns reload off
   assign walk_ptbr_o  = ctrl_q[AW-1:10];
   assign walk_vaddr_o = vaddr_q;
   assign do_reload    = enable_i && !hit && walk_ptbr_o != '0;
   assign walk_start_o = lookup_q && do_reload;
   assign finish       = lookup_q && !do_reload;

   always_ff @(posedge clk) begin
      if (rst) begin
         busy_q       <= 1'b0;
         lookup_q     <= 1'b0;
         resp_valid_o <= 1'b0;
      end else begin
         // Arrays are read on acceptance and again after the settle cycle
         lookup_q <= accept || walk_done_i;
         if (accept) begin
            busy_q <= 1'b1;
         end else if (resp_valid_o && resp_ready_i) begin
            busy_q <= 1'b0;
         end
         if (finish || walk_fault_i) begin
            resp_valid_o <= 1'b1;
         end else if (resp_ready_i) begin
            resp_valid_o <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         vaddr_q <= req_vaddr_i;
         store_q <= req_store_i;
         super_q <= req_super_i;
      end
      if (finish || walk_fault_i) begin
         // Pass-through unless a hit says otherwise
         resp_paddr_o         <= vaddr_q;
         resp_cache_inhibit_o <= 1'b0;
         resp_miss_o          <= 1'b0;
         resp_pagefault_o     <= 1'b0;
         resp_reload_fault_o  <= walk_fault_i;
         if (finish && enable_i && hit) begin
            resp_paddr_o         <= {a_trans_i.ppn, vaddr_q[PB-1:0]};
            resp_cache_inhibit_o <= a_trans_i.attr[1];
            resp_pagefault_o     <= !perm_ok;
         end else if (finish && enable_i) begin
            resp_miss_o <= 1'b1;
         end
      end
   end

   // SPR decode, only group 1 answers
   assign spr_group = spr_addr_i[15:11] == 5'(`MMU_SPR_GROUP);
   assign spr_first = spr_stb_i && spr_group && !spr_ack_o;
   assign spr_wr    = spr_first && spr_we_i;

   always_comb begin
      spr_sel = SPR_SEL_NONE;
      if (spr_addr_i == SPR_DMMUCR_ADDR) begin
         spr_sel = SPR_SEL_CTRL;
      end else if (spr_addr_i >= SPR_DTLB_MATCH_BASE && spr_addr_i < SPR_DTLB_TRANS_BASE) begin
         spr_sel = SPR_SEL_MATCH;
      end else if (spr_addr_i >= SPR_DTLB_TRANS_BASE && spr_addr_i < SPR_DTLB_WAY_END) begin
         spr_sel = SPR_SEL_TRANS;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         spr_ack_o <= 1'b0;
         spr_sel_q <= SPR_SEL_NONE;
         ctrl_q    <= '0;
      end else begin
         spr_ack_o <= spr_first;
         spr_sel_q <= spr_first ? spr_sel : SPR_SEL_NONE;
         if (spr_wr && spr_sel == SPR_SEL_CTRL) begin
            ctrl_q <= spr_dat_i;
         end
      end
   end

   // Read data lines up with the acknowledge
   always_comb begin
      case (spr_sel_q)
         SPR_SEL_CTRL:  spr_dat_o = ctrl_q;
         SPR_SEL_MATCH: spr_dat_o = b_match_i;
         SPR_SEL_TRANS: spr_dat_o = b_trans_i;
         default:       spr_dat_o = '0;
      endcase
   end

   // Port B, strobe wins over refill
   assign refill_wr    = refill_we_i && !spr_stb_i;
   assign b_addr_o     = spr_stb_i ? spr_addr_i[SW-1:0] : vaddr_q[PB+SW-1:PB];
   assign b_we_match_o = (spr_wr && spr_sel == SPR_SEL_MATCH) || refill_wr;
   assign b_we_trans_o = (spr_wr && spr_sel == SPR_SEL_TRANS) || refill_wr;
   assign b_wmatch_o   = spr_stb_i ? match_entry_t'(spr_dat_i) : refill_match_i;
   assign b_wtrans_o   = spr_stb_i ? trans_entry_t'(spr_dat_i) : refill_trans_i;

   // Port A data is unused during any port B write
   assign lookup_set = busy_q ? vaddr_q[PB+SW-1:PB] : req_vaddr_i[PB+SW-1:PB];
   assign a_addr_o   = (b_we_match_o || b_we_trans_o) ? ~b_addr_o : lookup_set;

   a_resp_stable: assert property (
      @(posedge clk) disable iff (rst)
      resp_valid_o && !resp_ready_i |=> resp_valid_o && $stable(resp_paddr_o) &&
         $stable({resp_cache_inhibit_o, resp_miss_o, resp_pagefault_o, resp_reload_fault_o})
   ) else $error("response changed under back-pressure");

endmodule

// File: design/dmmu_top.sv
// Data MMU subsystem with lookup logic, match and translate arrays and reload walker
`include "mmu_settings.svh"

module dmmu_top
   import mmu_types_pkg::*;
(
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       enable_i,
   input  logic                       req_valid_i,
   output logic                       req_ready_o,
   input  logic [`MMU_ADDR_WIDTH-1:0] req_vaddr_i,
   input  logic                       req_store_i,
   input  logic                       req_super_i,
   output logic                       resp_valid_o,
   input  logic                       resp_ready_i,
   output logic [`MMU_ADDR_WIDTH-1:0] resp_paddr_o,
   output logic                       resp_cache_inhibit_o,
   output logic                       resp_miss_o,
   output logic                       resp_pagefault_o,
   output logic                       resp_reload_fault_o,
   input  logic                       spr_stb_i,
   input  logic                       spr_we_i,
   input  logic [15:0]                spr_addr_i,
   input  logic [`MMU_ADDR_WIDTH-1:0] spr_dat_i,
   output logic [`MMU_ADDR_WIDTH-1:0] spr_dat_o,
   output logic                       spr_ack_o,
   output logic                       mem_req_o,
   output logic [`MMU_ADDR_WIDTH-1:0] mem_addr_o,
   input  logic                       mem_ack_i,
   input  logic [`MMU_ADDR_WIDTH-1:0] mem_data_i
);

   logic [`MMU_SET_WIDTH-1:0]   a_addr;
   logic [`MMU_SET_WIDTH-1:0]   b_addr;
   logic                        b_we_match;
   logic                        b_we_trans;
   match_entry_t                b_wmatch;
   trans_entry_t                b_wtrans;
   match_entry_t                a_match;
   trans_entry_t                a_trans;
   match_entry_t                b_match;
   trans_entry_t                b_trans;
   logic                        walk_start;
   logic [`MMU_ADDR_WIDTH-1:0]  walk_vaddr;
   logic [`MMU_ADDR_WIDTH-11:0] walk_ptbr;
   logic                        walk_busy;
   logic                        walk_done;
   logic                        walk_fault;
   logic                        refill_we;
   match_entry_t                refill_match;
   trans_entry_t                refill_trans;

   dmmu u_dmmu (
      .clk, .rst, .enable_i,
      .req_valid_i, .req_ready_o, .req_vaddr_i, .req_store_i, .req_super_i,
      .resp_valid_o, .resp_ready_i, .resp_paddr_o, .resp_cache_inhibit_o,
      .resp_miss_o, .resp_pagefault_o, .resp_reload_fault_o,
      .spr_stb_i, .spr_we_i, .spr_addr_i, .spr_dat_i, .spr_dat_o, .spr_ack_o,
      .a_addr_o       (a_addr),
      .b_addr_o       (b_addr),
      .b_we_match_o   (b_we_match),
      .b_we_trans_o   (b_we_trans),
      .b_wmatch_o     (b_wmatch),
      .b_wtrans_o     (b_wtrans),
      .a_match_i      (a_match),
      .a_trans_i      (a_trans),
      .b_match_i      (b_match),
      .b_trans_i      (b_trans),
      .walk_start_o   (walk_start),
      .walk_vaddr_o   (walk_vaddr),
      .walk_ptbr_o    (walk_ptbr),
      .walk_busy_i    (walk_busy),
      .walk_done_i    (walk_done),
      .walk_fault_i   (walk_fault),
      .refill_we_i    (refill_we),
      .refill_match_i (refill_match),
      .refill_trans_i (refill_trans)
   );

   tlb_dpram #(.entry_t(match_entry_t), .ADDR_WIDTH(`MMU_SET_WIDTH)) u_match_ram (
      .clk,
      .a_addr_i  (a_addr),
      .a_rdata_o (a_match),
      .b_addr_i  (b_addr),
      .b_we_i    (b_we_match),
      .b_wdata_i (b_wmatch),
      .b_rdata_o (b_match)
   );

   tlb_dpram #(.entry_t(trans_entry_t), .ADDR_WIDTH(`MMU_SET_WIDTH)) u_trans_ram (
      .clk,
      .a_addr_i  (a_addr),
      .a_rdata_o (a_trans),
      .b_addr_i  (b_addr),
      .b_we_i    (b_we_trans),
      .b_wdata_i (b_wtrans),
      .b_rdata_o (b_trans)
   );

   tlb_reload_walker u_walker (
      .clk, .rst,
      .walk_start_i   (walk_start),
      .walk_vaddr_i   (walk_vaddr),
      .walk_ptbr_i    (walk_ptbr),
      .walk_busy_o    (walk_busy),
      .walk_done_o    (walk_done),
      .walk_fault_o   (walk_fault),
      .mem_req_o, .mem_addr_o, .mem_ack_i, .mem_data_i,
      .refill_we_o    (refill_we),
      .refill_match_o (refill_match),
      .refill_trans_o (refill_trans)
   );

endmodule

// File: verif/dmmu_tb.sv
// Testbench for the data MMU subsystem with pattern reader, page-table memory model and checks
`include "mmu_settings.svh"

module dmmu_tb
   import mmu_types_pkg::*;
();

   localparam int AW           = `MMU_ADDR_WIDTH;
   localparam int NUM_RECS     = 64;
   localparam int TIMEOUT      = 200;
   localparam int NOACK_WINDOW = 12;

   logic          clk;
   logic          rst;
   logic          enable_i;
   logic          req_valid_i;
   logic          req_ready_o;
   logic [AW-1:0] req_vaddr_i;
   logic          req_store_i;
   logic          req_super_i;
   logic          resp_valid_o;
   logic          resp_ready_i;
   logic [AW-1:0] resp_paddr_o;
   logic          resp_cache_inhibit_o;
   logic          resp_miss_o;
   logic          resp_pagefault_o;
   logic          resp_reload_fault_o;
   logic          spr_stb_i;
   logic          spr_we_i;
   logic [15:0]   spr_addr_i;
   logic [AW-1:0] spr_dat_i;
   logic [AW-1:0] spr_dat_o;
   logic          spr_ack_o;
   logic          mem_req_o;
   logic [AW-1:0] mem_addr_o;
   logic          mem_ack_i;
   logic [AW-1:0] mem_data_i;

   // Tag nibble, then fields a, b and c of 32 bits each
   logic [99:0]   recs [0:NUM_RECS-1];
   logic [AW-1:0] image_addr [$];
   logic [AW-1:0] image_data [$];
   logic          random_ready;
   logic [31:0]   ready_seed;

   dmmu_top dut_i (.*);

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   function automatic logic [31:0] lcg_step(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // Upper LCG bits, the low ones repeat quickly
   function automatic logic draw_ready();
      if (!random_ready) begin
         return 1'b1;
      end
      ready_seed = lcg_step(ready_seed);
      return ready_seed[20];
   endfunction

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("TESTS FAILED");
      $fatal(1);
   endtask

   task automatic report_mismatch(input string sig, input logic [AW-1:0] got,
                                  input logic [AW-1:0] exp);
      abort_run($sformatf("** Error: %s = 0x%h, expected 0x%h", sig, got, exp));
   endtask

   task automatic check_resp(input logic [AW-1:0] paddr, input logic ci, input logic miss,
                             input logic pf, input logic rf, input logic [AW-1:0] exp_paddr,
                             input logic [3:0] exp_flags);
      if (paddr !== exp_paddr) report_mismatch("resp_paddr_o", paddr, exp_paddr);
      if (ci !== exp_flags[0]) report_mismatch("resp_cache_inhibit_o", ci, exp_flags[0]);
      if (miss !== exp_flags[1]) report_mismatch("resp_miss_o", miss, exp_flags[1]);
      if (pf !== exp_flags[2]) report_mismatch("resp_pagefault_o", pf, exp_flags[2]);
      if (rf !== exp_flags[3]) report_mismatch("resp_reload_fault_o", rf, exp_flags[3]);
   endtask

   task automatic check_ctrl(input logic [AW-1:0] got, input logic [AW-1:0] exp);
      if (got !== exp) report_mismatch("spr_dat_o (control)", got, exp);
   endtask

   task automatic check_match(input match_entry_t got, input match_entry_t exp);
      if (got !== exp) report_mismatch("spr_dat_o (match entry)", got, exp);
   endtask

   task automatic check_trans(input trans_entry_t got, input trans_entry_t exp);
      if (got !== exp) report_mismatch("spr_dat_o (translate entry)", got, exp);
   endtask

   task automatic read_image(input logic [AW-1:0] addr, output logic [AW-1:0] data,
                             output logic found);
      found = 1'b0;
      data  = '0;
      foreach (image_addr[k]) begin
         if (image_addr[k] == addr) begin
            found = 1'b1;
            data  = image_data[k];
         end
      end
   endtask

   // Strobe held until the acknowledge, read data taken in that cycle
   task automatic spr_access(input logic we, input logic [15:0] addr,
                             input logic [AW-1:0] wdata, output logic [AW-1:0] rdata);
      int waited;
      spr_stb_i  = 1'b1;
      spr_we_i   = we;
      spr_addr_i = addr;
      spr_dat_i  = wdata;
      waited     = 0;
      @(negedge clk);
      while (!spr_ack_o) begin
         waited++;
         if (waited > TIMEOUT) abort_run($sformatf("Timeout waiting for spr_ack_o at 0x%h", addr));
         @(negedge clk);
      end
      rdata     = spr_dat_o;
      spr_stb_i = 1'b0;
      spr_we_i  = 1'b0;
   endtask

   task automatic spr_no_ack(input logic [15:0] addr);
      spr_stb_i  = 1'b1;
      spr_we_i   = 1'b0;
      spr_addr_i = addr;
      for (int n = 0; n < NOACK_WINDOW; n++) begin
         @(negedge clk);
         if (spr_ack_o) abort_run($sformatf("SPR access at 0x%h outside group 1 was acknowledged",
                                            addr));
      end
      spr_stb_i = 1'b0;
   endtask

   task automatic run_request(input logic [99:0] rec);
      logic [AW-1:0] exp_paddr;
      logic [31:0]   fl;
      int            waited;
      int            cycles;
      logic          moved;
      exp_paddr = rec[63:32];
      fl        = rec[31:0];
      waited    = 0;
      while (!req_ready_o) begin
         @(negedge clk);
         waited++;
         if (waited > TIMEOUT) abort_run("Timeout waiting for req_ready_o");
      end
      enable_i    = fl[2];
      req_vaddr_i = rec[95:64];
      req_store_i = fl[0];
      req_super_i = fl[1];
      req_valid_i = 1'b1;
      @(negedge clk);
      req_valid_i = 1'b0;
      if (req_ready_o) abort_run("Request was not accepted while req_ready_o was high");
      cycles = 0;
      while (!resp_valid_o) begin
         resp_ready_i = draw_ready();
         @(negedge clk);
         cycles++;
         if (cycles > TIMEOUT) abort_run("Timeout waiting for resp_valid_o");
      end
      if (fl[3] && cycles != 1) begin
         abort_run($sformatf("Response came %0d cycles after acceptance instead of one", cycles));
      end
      moved  = 1'b0;
      waited = 0;
      while (!moved) begin
         check_resp(resp_paddr_o, resp_cache_inhibit_o, resp_miss_o, resp_pagefault_o,
                    resp_reload_fault_o, exp_paddr, fl[7:4]);
         resp_ready_i = draw_ready();
         @(negedge clk);
         if (resp_ready_i) begin
            moved = 1'b1;
            if (resp_valid_o) abort_run("Response stayed valid after its transfer");
         end else begin
            waited++;
            if (!resp_valid_o) abort_run("Response dropped before resp_ready_i was high");
            if (waited > TIMEOUT) abort_run("Timeout waiting for the response transfer");
         end
      end
   endtask

   // Page-table memory with a random acknowledge delay
   initial begin
      logic [AW-1:0] word;
      logic          found;
      logic [31:0]   mem_seed;
      int unsigned   mem_delay;
      mem_ack_i  = 1'b0;
      mem_data_i = '0;
      mem_seed   = 32'hae73_f875;
      mem_delay  = 0;
      forever begin
         @(negedge clk);
         if (mem_ack_i) begin
            mem_ack_i = 1'b0;
            mem_seed  = lcg_step(mem_seed);
            mem_delay = mem_seed[18:17];
         end else if (mem_req_o === 1'b1) begin
            if (mem_delay == 0) begin
               read_image(mem_addr_o, word, found);
               if (!found) abort_run($sformatf("Walker read 0x%h, outside the memory image",
                                               mem_addr_o));
               mem_ack_i  = 1'b1;
               mem_data_i = word;
            end else begin
               mem_delay--;
            end
         end
      end
   end

   initial begin
      logic          at_end;
      logic [AW-1:0] rdata;
      rst          = 1'b1;
      enable_i     = 1'b0;
      req_valid_i  = 1'b0;
      req_vaddr_i  = '0;
      req_store_i  = 1'b0;
      req_super_i  = 1'b0;
      resp_ready_i = 1'b1;
      spr_stb_i    = 1'b0;
      spr_we_i     = 1'b0;
      spr_addr_i   = '0;
      spr_dat_i    = '0;
      random_ready = 1'b0;
      ready_seed   = 32'hae73_f875;
      $readmemh("verif/dmmu_patterns.hex", recs);
      for (int i = 0; i < NUM_RECS; i++) begin
         if (recs[i][99:96] == 4'h0) begin
            image_addr.push_back(recs[i][95:64]);
            image_data.push_back(recs[i][63:32]);
         end
      end
      repeat (16) @(negedge clk);
      rst = 1'b0;
      if (req_ready_o !== 1'b1) report_mismatch("req_ready_o", req_ready_o, 1'b1);
      if (resp_valid_o !== 1'b0) report_mismatch("resp_valid_o", resp_valid_o, 1'b0);
      if (spr_ack_o !== 1'b0) report_mismatch("spr_ack_o", spr_ack_o, 1'b0);
      if (mem_req_o !== 1'b0) report_mismatch("mem_req_o", mem_req_o, 1'b0);
      at_end = 1'b0;
      for (int i = 0; i < NUM_RECS && !at_end; i++) begin
         case (recs[i][99:96])
            // Memory words went to the image before reset
            4'h0: begin
            end
            4'h1: spr_access(1'b1, recs[i][79:64], recs[i][63:32], rdata);
            4'h2: begin
               spr_access(1'b0, recs[i][79:64], '0, rdata);
               case (recs[i][1:0])
                  2'd0:    check_ctrl(rdata, recs[i][63:32]);
                  2'd1:    check_match(match_entry_t'(rdata), match_entry_t'(recs[i][63:32]));
                  default: check_trans(trans_entry_t'(rdata), trans_entry_t'(recs[i][63:32]));
               endcase
            end
            4'h3: spr_no_ack(recs[i][79:64]);
            4'h4: run_request(recs[i]);
            4'h5: random_ready = recs[i][0];
            4'hf: at_end = 1'b1;
            default: abort_run($sformatf("Pattern record %0d has an unknown tag", i));
         endcase
      end
      if (!at_end) begin
         abort_run("Pattern file ends without an end record");
      end else begin
         $display("TESTS PASSED");
         $finish;
      end
   end

endmodule

// File: project.f
+incdir+design
design/mmu_types_pkg.sv
design/spr_map_pkg.sv
design/tlb_dpram.sv
design/tlb_reload_walker.sv
design/dmmu.sv
design/dmmu_top.sv
verif/dmmu_tb.sv

// File: verif/dmmu_patterns.hex
// Columns: tag_a_b_c. Tag 0 memory word (a address, b data), 1 SPR write (a address, b data),
// 2 SPR read (a address, b expected, c 0 control 1 match 2 translate), 3 SPR without ack,
// 4 request (a vaddr, b expected paddr, c flags), 5 back-pressure (c 1 random), f end.
// Request flags: 01 store, 02 supervisor, 04 enable, 08 one-cycle response,
// 10 cache inhibit, 20 miss, 40 page fault, 80 reload fault
0_00004048_00006000_00000000
0_0000668c_01578482_00000000
0_00006690_00040441_00000000
0_00004080_00000000_00000000
0_000040c0_00006200_00000000
0_00006004_00012080_00000000
1_00000800_12345678_00000000
2_00000800_12345678_00000000
1_00000800_00000000_00000000
2_00000800_00000000_00000000
1_00000a05_0000a001_00000000
1_00000a85_000fe140_00000000
1_00000a06_0000c001_00000000
1_00000a86_02468342_00000000
1_00000a07_0000e001_00000000
1_00000a87_000aa3c0_00000000
1_00000a23_00000000_00000000
1_00000a24_00000000_00000000
1_00000a00_00000000_00000000
1_00000a01_00000000_00000000
2_00000a05_0000a001_00000001
2_00000a06_0000c001_00000001
2_00000a85_000fe140_00000002
2_00000a87_000aa3c0_00000002
2_00000a23_00000000_00000001
3_00001800_00000000_00000000
3_00000000_00000000_00000000
5_00000000_00000000_00000000
4_0000a123_000fe123_0000000c
4_0000a123_000fe123_0000004d
4_0000a123_000fe123_0000000e
4_0000a123_000fe123_0000004f
4_0000c456_02468456_0000001c
4_0000c456_02468456_0000005d
4_0000c456_02468456_0000001f
4_0000e010_000aa010_0000000d
4_0000a123_0000a123_00000009
4_deadbee8_deadbee8_0000000a
4_12346abc_12346abc_0000002f
1_00000800_00004000_00000000
4_12346abc_01578abc_00000017
2_00000a23_12346001_00000001
2_00000aa3_01578302_00000002
4_12346abc_01578abc_0000005c
4_20000000_20000000_00000086
4_30000000_30000000_00000084
4_12002000_12002000_00000087
5_00000000_00000000_00000001
4_0000a123_000fe123_0000000e
4_0000c456_02468456_0000005d
4_12346abc_01578abc_0000005c
4_12348004_00040004_00000004
4_12348004_00040004_0000000c
4_0000e010_0000e010_00000009
4_20000000_20000000_00000086
f_00000000_00000000_00000000
